/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
TOP       ?= decodeTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* dv/clockGen.sv */
// Free-running 10 ns clock; arstN is released by a non-blocking write on the fifth rising edge
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Flops still see reset on the release edge
    initial begin
        arstN = 1'b0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

/* dv/decodeTb.sv */
// Expected read data in the table assumes wbDelay = 3; a change of wbDelay needs new rows
`timescale 1ns/10ps

module decodeTb;
    import decodePkg::*;

    localparam int wbDelay = 3;
    localparam int numEntries = 18;
    localparam logic [15:0] nopInstr = 16'h0800;

    typedef struct packed {
        logic [15:0] instr;
        logic [15:0] wbData;
        logic [6:0]  flags;
        logic [1:0]  bSrc;
        branchCondT  branch;
        aluOpT       oper;
        logic [2:0]  aluInv;
        logic        regWrt;
        logic [2:0]  rd;
        resultSrcT   regSrc;
        logic [15:0] rsData;
        logic [15:0] rtData;
    } entryT;

    logic clk, arstN;
    logic [15:0] instr, pc, wbData;
    logic nHalt, nHaltComb, memRead, memWrt, immSrc, aluSign, aluJmp, err;
    logic regWrt, invA, invB, cIn;
    logic [1:0] bSrc;
    logic [2:0] rd;
    resultSrcT regSrc;
    branchCondT branchTaken;
    aluOpT oper;
    logic [15:0] rsData, rtData, imm5, imm8, sImm8, sImm11, pcNext;

    entryT tbl [numEntries];
    logic [15:0] pcLog [numEntries];
    // Writeback expectations in issue order: {regWrt, rd, regSrc, wbData}
    logic [21:0] wbQ [$];
    integer seed;

    clockGen clockGen_inst (.clk(clk), .arstN(arstN));

    // Port names match the local signals
    decodeTop #(.wbDelay(wbDelay)) decodeTop_inst (.*);

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] want);
        if (got !== want) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
            $display("=== FAIL ===");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Columns: instr, wbData, nHalt memRead memWrt immSrc aluSign aluJmp err, bSrc,
    // branchTaken, oper, invA invB cIn, regWrt, rd, regSrc, rsData, rtData
    task automatic loadTable();
        tbl[0]  = '{16'hC1A5, 16'hFFA5, 7'b1001000, 2'd2, none, opPass, 3'b000,
                    1'b1, 3'd1, immediate, 16'h0000, 16'h0000};
        tbl[1]  = '{16'h92C3, 16'h1234, 7'b1001000, 2'd2, none, opPass, 3'b000,
                    1'b1, 3'd2, immediate, 16'h0000, 16'h0000};
        tbl[2]  = '{16'h5176, 16'h0F0F, 7'b1001000, 2'd1, none, opXor, 3'b000,
                    1'b1, 3'd3, aluResult, 16'h0000, 16'h0000};
        // r1 is written on the edge that samples this read
        tbl[3]  = '{16'h4199, 16'hBEEF, 7'b1001100, 2'd1, none, opAdd, 3'b000,
                    1'b1, 3'd4, aluResult, 16'h0000, 16'h0000};
        tbl[4]  = '{16'h8140, 16'h0000, 7'b1011100, 2'd1, none, opAdd, 3'b000,
                    1'b0, 3'd2, aluResult, 16'hFFA5, 16'h0000};
        // RALU with func 00, 01, 10 and 11
        tbl[5]  = '{16'hDA34, 16'h0005, 7'b1000000, 2'd0, none, opAdd, 3'b000,
                    1'b1, 3'd5, aluResult, 16'h1234, 16'hFFA5};
        tbl[6]  = '{16'hDB99, 16'h6666, 7'b1000000, 2'd0, none, opAdd, 3'b101,
                    1'b1, 3'd6, aluResult, 16'h0F0F, 16'h0000};
        tbl[7]  = '{16'hDC1E, 16'h7777, 7'b1000000, 2'd0, none, opXor, 3'b000,
                    1'b1, 3'd7, aluResult, 16'hBEEF, 16'h0000};
        tbl[8]  = '{16'hDDC3, 16'h0A0A, 7'b1000000, 2'd0, none, opAndn, 3'b010,
                    1'b1, 3'd0, aluResult, 16'h0000, 16'h0000};
        tbl[9]  = '{16'h8D27, 16'hCAFE, 7'b1101100, 2'd1, none, opAdd, 3'b000,
                    1'b1, 3'd1, memData, 16'h0005, 16'hFFA5};
        tbl[10] = '{16'h6605, 16'h0000, 7'b1000000, 2'd0, eqZero, opPass, 3'b000,
                    1'b0, 3'd0, aluResult, 16'h6666, 16'h0000};
        tbl[11] = '{16'h6F81, 16'h0000, 7'b1000000, 2'd0, neZero, opPass, 3'b000,
                    1'b0, 3'd4, aluResult, 16'h7777, 16'hBEEF};
        tbl[12] = '{16'h2403, 16'h0000, 7'b1001110, 2'd3, alwaysTaken, opAdd, 3'b000,
                    1'b0, 3'd0, aluResult, 16'hBEEF, 16'h0A0A};
        tbl[13] = '{16'h3008, 16'h1357, 7'b1001110, 2'd3, alwaysTaken, opAdd, 3'b000,
                    1'b1, 3'd7, pcLink, 16'h0A0A, 16'h0A0A};
        // Unknown opcode, then HALT
        tbl[14] = '{16'hF800, 16'h0000, 7'b1000001, 2'd0, none, opPass, 3'b000,
                    1'b0, 3'd0, aluResult, 16'h0A0A, 16'h0A0A};
        tbl[15] = '{16'h0000, 16'h0000, 7'b0000000, 2'd0, none, opPass, 3'b000,
                    1'b0, 3'd0, aluResult, 16'h0A0A, 16'h0A0A};
        tbl[16] = '{16'h81E0, 16'h0000, 7'b1011100, 2'd1, none, opAdd, 3'b000,
                    1'b0, 3'd7, aluResult, 16'hCAFE, 16'h7777};
        tbl[17] = '{16'h8760, 16'h0000, 7'b1011100, 2'd1, none, opAdd, 3'b000,
                    1'b0, 3'd3, aluResult, 16'h1357, 16'h0F0F};
    endtask

    // {imm5, imm8, sImm8, sImm11}; XORI and SLBI zero-extend
    function automatic logic [63:0] expectedImmediates(input logic [15:0] ins);
        logic zeroExtend;
        logic [15:0] i5, i8, s8, s11;
        zeroExtend = (ins[15:11] == 5'b01010) || (ins[15:11] == 5'b10010);
        s8  = {{8{ins[7]}}, ins[7:0]};
        s11 = {{5{ins[10]}}, ins[10:0]};
        i5  = zeroExtend ? {11'b0, ins[4:0]} : {{11{ins[4]}}, ins[4:0]};
        i8  = zeroExtend ? {8'b0, ins[7:0]} : s8;
        return {i5, i8, s8, s11};
    endfunction

    task automatic checkRegistered(input int k);
        entryT e;
        logic [63:0] imms;
        e = tbl[k];
        imms = expectedImmediates(e.instr);
        checkValue("nHalt memRead memWrt immSrc aluSign aluJmp err",
                   16'({nHalt, memRead, memWrt, immSrc, aluSign, aluJmp, err}), 16'(e.flags));
        checkValue("bSrc", 16'(bSrc), 16'(e.bSrc));
        checkValue("branchTaken", 16'(branchTaken), 16'(e.branch));
        checkValue("oper", 16'(oper), 16'(e.oper));
        checkValue("invA invB cIn", 16'({invA, invB, cIn}), 16'(e.aluInv));
        checkValue("rsData", rsData, e.rsData);
        checkValue("rtData", rtData, e.rtData);
        checkValue("pcNext", pcNext, pcLog[k]);
        checkValue("imm5", imm5, imms[63:48]);
        checkValue("imm8", imm8, imms[47:32]);
        checkValue("sImm8", sImm8, imms[31:16]);
        checkValue("sImm11", sImm11, imms[15:0]);
    endtask

    task automatic checkWriteback(input logic [21:0] w);
        checkValue("regWrt", 16'(regWrt), 16'(w[21]));
        if (w[21]) begin
            checkValue("rd", 16'(rd), 16'(w[20:18]));
            checkValue("regSrc", 16'(regSrc), 16'(w[17:16]));
        end
    endtask

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        while (arstN !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                $display("Reset was never released within 20 clock cycles");
                $display("=== FAIL ===");
                $fatal(1, "Reset timeout");
            end
        end
    endtask

    initial begin
        int i;
        instr  <= nopInstr;
        pc     <= '0;
        wbData <= '0;
        seed = 32'h5e92_b37a;
        loadTable();
        waitForReset();

        // Nothing decoded yet
        checkValue("regWrt after reset", 16'(regWrt), 16'h0);
        checkValue("memRead after reset", 16'(memRead), 16'h0);
        checkValue("memWrt after reset", 16'(memWrt), 16'h0);
        checkValue("err after reset", 16'(err), 16'h0);
        checkValue("nHalt after reset", 16'(nHalt), 16'h0);

        // Drain with NOPs so the last writes leave the delay line
        for (i = 0; i < numEntries + wbDelay; i++) begin
            @(posedge clk);
            if (i < numEntries) begin
                pcLog[i] = 16'($random(seed));
                instr <= tbl[i].instr;
                pc    <= pcLog[i];
                wbQ.push_back({tbl[i].regWrt, tbl[i].rd, tbl[i].regSrc, tbl[i].wbData});
            end else begin
                instr <= nopInstr;
                pc    <= '0;
                wbQ.push_back(22'h0);
            end
            // Write data goes with the instruction now at the end of the delay line
            if (wbQ.size() > wbDelay) begin
                wbData <= wbQ[0][15:0];
            end else begin
                wbData <= '0;
            end

            @(negedge clk);
            if (i < numEntries) begin
                checkValue("nHaltComb", 16'(nHaltComb), 16'(tbl[i].flags[6]));
            end
            if (i >= 1 && i <= numEntries) begin
                checkRegistered(i - 1);
            end
            if (wbQ.size() > wbDelay) begin
                checkWriteback(wbQ.pop_front());
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* source/aluControl.sv */
// Combinational; SUB is formed as rt - rs, i.e. ~rs + rt + 1 at the execute adder
`timescale 1ns/10ps

module aluControl (
    input  decodePkg::aluClassT aluClass,
    input  logic [1:0]          func,
    output decodePkg::aluOpT    oper,
    output logic                invA,
    output logic                invB,
    output logic                cIn
);
    import decodePkg::*;

    always_comb begin
        oper = opPass;
        invA = 1'b0;
        invB = 1'b0;
        cIn  = 1'b0;
        case (aluClass)
            add, jumpAdd: oper = opAdd;
            xorOp:        oper = opXor;
            pass:         oper = opPass;
            regFunc: begin
                case (func)
                    2'b00: oper = opAdd;
                    2'b01: begin
                        // Subtract
                        oper = opAdd;
                        invA = 1'b1;
                        cIn  = 1'b1;
                    end
                    2'b10: oper = opXor;
                    default: begin
                        oper = opAndn;
                        invB = 1'b1;
                    end
                endcase
            end
            default: oper = opPass;
        endcase
    end

endmodule

/* source/controlDecoder.sv */
// Purely combinational; bSrc 00=rt 01=imm5 10=imm8 11=sImm11, unknown opcodes raise illegal
`timescale 1ns/10ps

module controlDecoder (
    input  logic [decodePkg::wordW-1:0] instr,
    output logic                        nHalt,
    output logic                        memRead,
    output logic                        memWrt,
    output decodePkg::regDstT           regDst,
    output logic                        regWrt,
    output logic                        zeroExt,
    output logic [1:0]                  bSrc,
    output logic                        immSrc,
    output decodePkg::aluClassT         aluClass,
    output logic                        aluSign,
    output logic                        aluJmp,
    output decodePkg::resultSrcT        regSrc,
    output decodePkg::branchCondT       branchTaken,
    output logic                        illegal
);
    import decodePkg::*;

    opcodeT opcode;

    assign opcode = opcodeT'(instr[15:11]);

    always_comb begin
        // Defaults describe a NOP
        nHalt       = 1'b1;
        memRead     = 1'b0;
        memWrt      = 1'b0;
        regDst      = fieldRt;
        regWrt      = 1'b0;
        zeroExt     = 1'b0;
        bSrc        = 2'b00;
        immSrc      = 1'b0;
        aluClass    = pass;
        aluSign     = 1'b0;
        aluJmp      = 1'b0;
        regSrc      = aluResult;
        branchTaken = none;
        illegal     = 1'b0;

        case (opcode)
            HALT: nHalt = 1'b0;
            NOP: ;
            ADDI, LD, ST: begin
                bSrc     = 2'b01;
                immSrc   = 1'b1;
                aluClass = add;
                aluSign  = 1'b1;
                // Loads and stores share the rs + imm5 address
                regWrt   = (opcode != ST);
                memRead  = (opcode == LD);
                memWrt   = (opcode == ST);
                regSrc   = (opcode == LD) ? memData : aluResult;
            end
            XORI: begin
                regWrt   = 1'b1;
                zeroExt  = 1'b1;
                bSrc     = 2'b01;
                immSrc   = 1'b1;
                aluClass = xorOp;
            end
            LBI, SLBI: begin
                regDst  = fieldRs;
                regWrt  = 1'b1;
                zeroExt = (opcode == SLBI);
                bSrc    = 2'b10;
                immSrc  = 1'b1;
                regSrc  = immediate;
            end
            RALU: begin
                regDst   = fieldRd;
                regWrt   = 1'b1;
                aluClass = regFunc;
            end
            BEQZ: branchTaken = eqZero;
            BNEZ: branchTaken = neZero;
            J, JAL: begin
                bSrc        = 2'b11;
                immSrc      = 1'b1;
                aluClass    = jumpAdd;
                aluSign     = 1'b1;
                aluJmp      = 1'b1;
                branchTaken = alwaysTaken;
                if (opcode == JAL) begin
                    regDst = link;
                    regWrt = 1'b1;
                    regSrc = pcLink;
                end
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

/* source/decodePkg.sv */
// Encodings for the 16-bit, eight-register ISA; all-zero values are the reset values downstream
package decodePkg;

    // Register selector and data word widths
    localparam int regSelW = 3;
    localparam int wordW = 16;

    // Opcode in instr[15:11]
    typedef enum logic [4:0] {
        HALT = 5'b00000,
        NOP  = 5'b00001,
        J    = 5'b00100,
        JAL  = 5'b00110,
        ADDI = 5'b01000,
        XORI = 5'b01010,
        BEQZ = 5'b01100,
        BNEZ = 5'b01101,
        ST   = 5'b10000,
        LD   = 5'b10001,
        SLBI = 5'b10010,
        LBI  = 5'b11000,
        RALU = 5'b11011
    } opcodeT;

    // Which instruction field names the destination register
    typedef enum logic [1:0] {
        fieldRt = 2'b00,
        fieldRs = 2'b01,
        fieldRd = 2'b10,
        link    = 2'b11
    } regDstT;

    // Writeback value source
    typedef enum logic [1:0] {
        aluResult = 2'b00,
        memData   = 2'b01,
        pcLink    = 2'b10,
        immediate = 2'b11
    } resultSrcT;

    // Branch condition tested at execute
    typedef enum logic [3:0] {
        none        = 4'b0000,
        eqZero      = 4'b0001,
        neZero      = 4'b0010,
        alwaysTaken = 4'b0011
    } branchCondT;

    // Coarse ALU class from the main decoder
    typedef enum logic [2:0] {
        add     = 3'b000,
        xorOp   = 3'b001,
        pass    = 3'b010,
        jumpAdd = 3'b011,
        regFunc = 3'b100
    } aluClassT;

    // Operation sent to the execute stage ALU
    typedef enum logic [3:0] {
        opAdd  = 4'b0000,
        opXor  = 4'b0001,
        opAndn = 4'b0010,
        opPass = 4'b0011
    } aluOpT;

endpackage

/* source/decodeStage.sv */
// No stall or flush; wbDelay must be at least 1 and all registered outputs reset to zero
`timescale 1ns/10ps

module decodeStage #(
    parameter int wbDelay = 3
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [decodePkg::wordW-1:0]   instr,
    input  logic [decodePkg::wordW-1:0]   pc,
    input  logic [decodePkg::wordW-1:0]   rsRaw,
    input  logic [decodePkg::wordW-1:0]   rtRaw,
    output logic                          nHalt,
    output logic                          nHaltComb,
    output logic                          memRead,
    output logic                          memWrt,
    output logic                          immSrc,
    output logic                          aluSign,
    output logic                          aluJmp,
    output logic                          err,
    output logic [1:0]                    bSrc,
    output decodePkg::branchCondT         branchTaken,
    output decodePkg::aluOpT              oper,
    output logic [decodePkg::wordW-1:0]   rsData,
    output logic [decodePkg::wordW-1:0]   rtData,
    output logic [decodePkg::wordW-1:0]   imm5,
    output logic [decodePkg::wordW-1:0]   imm8,
    output logic [decodePkg::wordW-1:0]   sImm8,
    output logic [decodePkg::wordW-1:0]   sImm11,
    output logic [decodePkg::wordW-1:0]   pcNext,
    output logic                          invA,
    output logic                          invB,
    output logic                          cIn,
    output logic                          regWrt,
    output logic [decodePkg::regSelW-1:0] rd,
    output decodePkg::resultSrcT          regSrc
);
    import decodePkg::*;

    logic nHaltDec, memReadDec, memWrtDec, regWrtDec, zeroExt;
    logic immSrcDec, aluSignDec, aluJmpDec, illegal;
    logic invADec, invBDec, cInDec;
    logic [1:0] bSrcDec;
    regDstT regDst;
    aluClassT aluClass;
    resultSrcT regSrcDec;
    branchCondT branchDec;
    aluOpT operDec;
    logic [regSelW-1:0] rdDec;
    logic [wordW-1:0] imm5Dec, imm8Dec, sImm8Dec, sImm11Dec;

    // Writeback delay line, oldest entry at the top index
    logic [wbDelay-1:0] wrtLine;
    logic [wbDelay-1:0][regSelW-1:0] rdLine;
    logic [wbDelay-1:0][1:0] srcLine;

    controlDecoder controlDecoder_inst (
        .instr(instr), .nHalt(nHaltDec), .memRead(memReadDec), .memWrt(memWrtDec),
        .regDst(regDst), .regWrt(regWrtDec), .zeroExt(zeroExt), .bSrc(bSrcDec),
        .immSrc(immSrcDec), .aluClass(aluClass), .aluSign(aluSignDec),
        .aluJmp(aluJmpDec), .regSrc(regSrcDec), .branchTaken(branchDec), .illegal(illegal)
    );

    aluControl aluControl_inst (
        .aluClass(aluClass), .func(instr[1:0]), .oper(operDec),
        .invA(invADec), .invB(invBDec), .cIn(cInDec)
    );

    always_comb begin
        case (regDst)
            fieldRt: rdDec = instr[7:5];
            fieldRs: rdDec = instr[10:8];
            fieldRd: rdDec = instr[4:2];
            default: rdDec = '1;
        endcase
    end

    // Immediate extension
    assign sImm8Dec  = {{(wordW-8){instr[7]}}, instr[7:0]};
    assign sImm11Dec = {{(wordW-11){instr[10]}}, instr[10:0]};
    assign imm5Dec   = zeroExt ? {{(wordW-5){1'b0}}, instr[4:0]}
                               : {{(wordW-5){instr[4]}}, instr[4:0]};
    assign imm8Dec   = zeroExt ? {{(wordW-8){1'b0}}, instr[7:0]} : sImm8Dec;

    // Halt seen by fetch in the same cycle
    assign nHaltComb = nHaltDec;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            {nHalt, memRead, memWrt, immSrc, aluSign, aluJmp, err} <= '0;
            {invA, invB, cIn} <= '0;
            bSrc        <= '0;
            branchTaken <= none;
            oper        <= opAdd;
            {rsData, rtData, pcNext} <= '0;
            {imm5, imm8, sImm8, sImm11} <= '0;
        end else begin
            {nHalt, memRead, memWrt} <= {nHaltDec, memReadDec, memWrtDec};
            {immSrc, aluSign, aluJmp, err} <= {immSrcDec, aluSignDec, aluJmpDec, illegal};
            {invA, invB, cIn} <= {invADec, invBDec, cInDec};
            bSrc        <= bSrcDec;
            branchTaken <= branchDec;
            oper        <= operDec;
            {rsData, rtData, pcNext} <= {rsRaw, rtRaw, pc};
            {imm5, imm8, sImm8, sImm11} <= {imm5Dec, imm8Dec, sImm8Dec, sImm11Dec};
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrtLine <= '0;
            rdLine  <= '0;
            srcLine <= '0;
        end else begin
            wrtLine[0] <= regWrtDec;
            rdLine[0]  <= rdDec;
            srcLine[0] <= regSrcDec;
            for (int i = 1; i < wbDelay; i++) begin
                wrtLine[i] <= wrtLine[i-1];
                rdLine[i]  <= rdLine[i-1];
                srcLine[i] <= srcLine[i-1];
            end
        end
    end

    assign regWrt = wrtLine[wbDelay-1];
    assign rd     = rdLine[wbDelay-1];
    assign regSrc = resultSrcT'(srcLine[wbDelay-1]);

endmodule

/* source/decodeTop.sv */
// wbData must be valid in every cycle regWrt is high; it is written at the next rising edge
`timescale 1ns/10ps

module decodeTop #(
    parameter int wbDelay = 3
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [decodePkg::wordW-1:0]   instr,
    input  logic [decodePkg::wordW-1:0]   pc,
    input  logic [decodePkg::wordW-1:0]   wbData,
    output logic                          nHalt,
    output logic                          nHaltComb,
    output logic                          memRead,
    output logic                          memWrt,
    output logic                          immSrc,
    output logic                          aluSign,
    output logic                          aluJmp,
    output logic                          err,
    output logic                          regWrt,
    output decodePkg::resultSrcT          regSrc,
    output logic [1:0]                    bSrc,
    output decodePkg::branchCondT         branchTaken,
    output decodePkg::aluOpT              oper,
    output logic [decodePkg::wordW-1:0]   rsData,
    output logic [decodePkg::wordW-1:0]   rtData,
    output logic [decodePkg::wordW-1:0]   imm5,
    output logic [decodePkg::wordW-1:0]   imm8,
    output logic [decodePkg::wordW-1:0]   sImm8,
    output logic [decodePkg::wordW-1:0]   sImm11,
    output logic [decodePkg::wordW-1:0]   pcNext,
    output logic                          invA,
    output logic                          invB,
    output logic                          cIn,
    output logic [decodePkg::regSelW-1:0] rd
);
    import decodePkg::*;

    logic [wordW-1:0] rsRaw, rtRaw;

    // Read selectors come straight from the instruction fields
    registerFile registerFile_inst (
        .clk(clk), .arstN(arstN), .rsSel(instr[10:8]), .rtSel(instr[7:5]),
        .writeSel(rd), .writeData(wbData), .writeEn(regWrt),
        .rsRaw(rsRaw), .rtRaw(rtRaw)
    );

    decodeStage #(.wbDelay(wbDelay)) decodeStage_inst (
        .clk(clk), .arstN(arstN), .instr(instr), .pc(pc), .rsRaw(rsRaw), .rtRaw(rtRaw),
        .nHalt(nHalt), .nHaltComb(nHaltComb), .memRead(memRead), .memWrt(memWrt),
        .immSrc(immSrc), .aluSign(aluSign), .aluJmp(aluJmp), .err(err), .bSrc(bSrc),
        .branchTaken(branchTaken), .oper(oper), .rsData(rsData), .rtData(rtData),
        .imm5(imm5), .imm8(imm8), .sImm8(sImm8), .sImm11(sImm11), .pcNext(pcNext),
        .invA(invA), .invB(invB), .cIn(cIn), .regWrt(regWrt), .rd(rd), .regSrc(regSrc)
    );

endmodule

/* source/registerFile.sv */
// No write bypass: a read in the cycle of its write returns the old word
`timescale 1ns/10ps

module registerFile (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [decodePkg::regSelW-1:0] rsSel,
    input  logic [decodePkg::regSelW-1:0] rtSel,
    input  logic [decodePkg::regSelW-1:0] writeSel,
    input  logic [decodePkg::wordW-1:0]   writeData,
    input  logic                          writeEn,
    output logic [decodePkg::wordW-1:0]   rsRaw,
    output logic [decodePkg::wordW-1:0]   rtRaw
);
    import decodePkg::*;

    localparam int numRegs = 2 ** regSelW;

    logic [wordW-1:0] regs [numRegs];

    // Single write port, whole array cleared on reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    // Reads come straight from the array
    assign rsRaw = regs[rsSel];
    assign rtRaw = regs[rtSel];

endmodule

/* vlog.f */
source/decodePkg.sv
source/controlDecoder.sv
source/aluControl.sv
source/registerFile.sv
source/decodeStage.sv
source/decodeTop.sv
dv/clockGen.sv
dv/decodeTb.sv
